//--- rtl/rf_pkg.sv
package rf_pkg;

  //////////////////////////////////////////////////
  // register file geometry
  //////////////////////////////////////////////////

  // number of entries in the array
  localparam int RF_ENTRIES = 16;

  // entry address width
  localparam int RF_ADDR_W  = 4;

  // width of one entry
  localparam int RF_DATA_W  = 160;

  // one byte enable per 8-bit column
  localparam int RF_BYTES   = 20;

  // word enable k covers every bit whose index mod 4 is k
  localparam int RF_WORDS   = 4;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // entry address
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  // one entry of data, also used as a per-bit write mask
  typedef logic [RF_DATA_W-1:0] rf_data_t;

  // byte enables, bit j covers bits 8j..8j+7
  typedef logic [RF_BYTES-1:0]  rf_byte_wen_t;

  // word enables, interleaved inside each byte
  typedef logic [RF_WORDS-1:0]  rf_word_wen_t;

  // data or mask of one byte lane
  typedef logic [7:0]           rf_lane_t;

endpackage

//--- rtl/rf_write_port.sv
module rf_write_port import rf_pkg::*;
(
  input  logic         rd_clk,
  input  logic         reset_l,

  // write request from the core
  input  logic         wr_en,
  input  rf_addr_t     wr_adr,
  input  rf_data_t     din,
  input  rf_word_wen_t word_wen,
  input  rf_byte_wen_t byte_wen,

  // captured request toward the array
  output rf_addr_t     wr_adr_q,
  output rf_data_t     wr_data_q,
  output rf_data_t     wr_bit_mask
);

  logic         wr_en_q;
  rf_word_wen_t word_wen_q;
  rf_byte_wen_t byte_wen_q;

  //////////////////////////////////////////////////
  // request capture
  //////////////////////////////////////////////////

  // control part of the request
  always_ff @(posedge rd_clk)
  begin
    if (reset_l)
    begin
      wr_en_q  <= 1'b0;
      wr_adr_q <= '0;
    end
    else
    begin
      wr_en_q  <= wr_en;
      wr_adr_q <= wr_adr;
    end
  end

  // data and enables only matter while wr_en_q is set
  always_ff @(posedge rd_clk)
  begin
    wr_data_q  <= din;
    word_wen_q <= word_wen;
    byte_wen_q <= byte_wen;
  end

  //////////////////////////////////////////////////
  // per-bit mask expansion
  //////////////////////////////////////////////////

  // bit b is written when word enable (b mod 4) and byte enable (b div 8)
  // are both set, so the word enables repeat twice inside every byte
  always_comb
  begin
    for (int b = 0; b < RF_DATA_W; b++)
    begin
      wr_bit_mask[b] = wr_en_q
                     & word_wen_q[b % RF_WORDS]
                     & byte_wen_q[b / 8];
    end
  end

endmodule

//--- rtl/rf_byte_lane.sv
module rf_byte_lane import rf_pkg::*;
(
  input  logic     rd_clk,

  // write side, already captured by the write port
  input  rf_addr_t wr_adr,
  input  rf_lane_t wr_data,
  input  rf_lane_t wr_mask,

  // read side, address from the read port
  input  rf_addr_t rd_adr,
  output rf_lane_t rd_data
);

  localparam int LANE_W = $bits(rf_lane_t);

  //////////////////////////////////////////////////
  // storage for one 8-bit column
  //////////////////////////////////////////////////

  // contents are not cleared by reset
  rf_lane_t mem [RF_ENTRIES];

  // only the masked bits of the addressed entry change
  always_ff @(posedge rd_clk)
  begin
    for (int i = 0; i < LANE_W; i++)
    begin
      if (wr_mask[i])
      begin
        mem[wr_adr][i] <= wr_data[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // read
  //////////////////////////////////////////////////

  // combinational read, a write in the same cycle shows up only
  // after the clock edge that commits it
  assign rd_data = mem[rd_adr];

endmodule

//--- rtl/rf_array.sv
module rf_array import rf_pkg::*;
#(
  parameter int NUM_LANES = RF_BYTES
)
(
  input  logic     rd_clk,

  input  rf_addr_t wr_adr,
  input  rf_data_t wr_data,
  input  rf_data_t wr_bit_mask,

  input  rf_addr_t rd_adr,
  output rf_data_t rd_raw
);

  localparam int LANE_W = $bits(rf_lane_t);

  // read data coming back from each column
  rf_lane_t lane_rd [NUM_LANES];

  //////////////////////////////////////////////////
  // byte-sliced columns
  //////////////////////////////////////////////////

  // lane l holds bits 8l..8l+7 of every entry
  for (genvar l = 0; l < NUM_LANES; l++)
  begin : g_lane
    rf_byte_lane rf_byte_lane_i
    (
      .rd_clk  (rd_clk),
      .wr_adr  (wr_adr),
      .wr_data (wr_data[l*LANE_W +: LANE_W]),
      .wr_mask (wr_bit_mask[l*LANE_W +: LANE_W]),
      .rd_adr  (rd_adr),
      .rd_data (lane_rd[l])
    );
  end

  // put the columns back together into one entry
  // bits above the last lane read as zero
  always_comb
  begin
    rd_raw = '0;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      rd_raw[l*LANE_W +: LANE_W] = lane_rd[l];
    end
  end

endmodule

//--- rtl/rf_read_port.sv
module rf_read_port import rf_pkg::*;
(
  input  logic     rd_clk,
  input  logic     reset_l,

  // read request from the core
  input  logic     read_en,
  input  rf_addr_t rd_adr,

  // raw entry from the array for rd_adr_q
  input  rf_data_t rd_raw,

  // captured write, used for collision detection
  input  rf_addr_t wr_adr_q,
  input  rf_data_t wr_bit_mask,

  output rf_addr_t rd_adr_q,
  output rf_data_t dout
);

  logic     rd_en_q;
  logic     collide;
  rf_data_t rd_masked;

  //////////////////////////////////////////////////
  // request capture
  //////////////////////////////////////////////////

  always_ff @(posedge rd_clk)
  begin
    if (reset_l)
    begin
      rd_en_q  <= 1'b0;
      rd_adr_q <= '0;
    end
    else
    begin
      rd_en_q  <= read_en;
      rd_adr_q <= rd_adr;
    end
  end

  //////////////////////////////////////////////////
  // collision masking
  //////////////////////////////////////////////////

  // a write captured at the same edge to the same entry has not
  // committed yet, the bits it touches return zero instead of old data
  assign collide = (rd_adr_q == wr_adr_q);

  // wr_bit_mask is already zero when no write is pending
  always_comb
  begin
    if (collide)
    begin
      rd_masked = rd_raw & ~wr_bit_mask;
    end
    else
    begin
      rd_masked = rd_raw;
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  // dout holds its value when no read was captured
  always_ff @(posedge rd_clk)
  begin
    if (reset_l)
    begin
      dout <= '0;
    end
    else if (rd_en_q)
    begin
      dout <= rd_masked;
    end
  end

endmodule

//--- rtl/rf16x160_top.sv
module rf16x160_top import rf_pkg::*;
(
  input  logic         rd_clk,
  input  logic         reset_l,

  // write request
  input  logic         wr_en,
  input  rf_addr_t     wr_adr,
  input  rf_data_t     din,
  input  rf_word_wen_t word_wen,
  input  rf_byte_wen_t byte_wen,

  // read request
  input  logic         read_en,
  input  rf_addr_t     rd_adr,

  // read data, valid two edges after the request
  output rf_data_t     dout
);

  // captured write toward the array and the read port
  rf_addr_t wr_adr_q;
  rf_data_t wr_data_q;
  rf_data_t wr_bit_mask;

  // captured read address and raw array data
  rf_addr_t rd_adr_q;
  rf_data_t rd_raw;

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  rf_write_port rf_write_port_i
  (
    .rd_clk      (rd_clk),
    .reset_l     (reset_l),
    .wr_en       (wr_en),
    .wr_adr      (wr_adr),
    .din         (din),
    .word_wen    (word_wen),
    .byte_wen    (byte_wen),
    .wr_adr_q    (wr_adr_q),
    .wr_data_q   (wr_data_q),
    .wr_bit_mask (wr_bit_mask)
  );

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // one column per byte enable
  rf_array #(
    .NUM_LANES (RF_BYTES)
  ) rf_array_i
  (
    .rd_clk      (rd_clk),
    .wr_adr      (wr_adr_q),
    .wr_data     (wr_data_q),
    .wr_bit_mask (wr_bit_mask),
    .rd_adr      (rd_adr_q),
    .rd_raw      (rd_raw)
  );

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  rf_read_port rf_read_port_i
  (
    .rd_clk      (rd_clk),
    .reset_l     (reset_l),
    .read_en     (read_en),
    .rd_adr      (rd_adr),
    .rd_raw      (rd_raw),
    .wr_adr_q    (wr_adr_q),
    .wr_bit_mask (wr_bit_mask),
    .rd_adr_q    (rd_adr_q),
    .dout        (dout)
  );

endmodule

//--- tb/rf_tb_ref.svh
`ifndef RF_TB_REF_SVH
`define RF_TB_REF_SVH

// model of the array contents and of the dout register
rf_data_t    model_mem [RF_ENTRIES];
rf_data_t    model_dout;
logic [31:0] rng_state;

// xorshift32 step, state seeded by the testbench
function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// bits touched by a write, byte j bit i needs byte enable j and word enable i mod 4
function automatic rf_data_t expand_mask(logic en, rf_word_wen_t ww, rf_byte_wen_t bw);
  rf_data_t m;
  m = '0;
  for (int j = 0; j < RF_BYTES; j++)
  begin
    for (int i = 0; i < 8; i++)
    begin
      m[8*j + i] = en && bw[j] && ww[i % RF_WORDS];
    end
  end
  return m;
endfunction

// dout after one set of inputs is sampled, then the write lands in the model
function automatic rf_data_t predict_dout(logic rd, rf_addr_t ra, logic wr, rf_addr_t wa,
                                          rf_data_t d, rf_word_wen_t ww, rf_byte_wen_t bw);
  rf_data_t m;
  m = expand_mask(wr, ww, bw);
  if (rd)
  begin
    model_dout = model_mem[ra];
    // same-edge write to the same entry reads zero on its bits
    if (wr && (ra == wa))
    begin
      model_dout = model_dout & ~m;
    end
  end
  model_mem[wa] = (model_mem[wa] & ~m) | (d & m);
  return model_dout;
endfunction

`endif

//--- tb/rf_tb.sv
module rf_tb import rf_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DRAIN_LIMIT = 50;
  localparam int NUM_TESTS   = 6;

  logic         rd_clk;
  logic         reset_l;
  logic         wr_en;
  rf_addr_t     wr_adr;
  rf_data_t     din;
  rf_word_wen_t word_wen;
  rf_byte_wen_t byte_wen;
  logic         read_en;
  rf_addr_t     rd_adr;
  rf_data_t     dout;

  int edge_cnt  = 0;
  int err_cnt   = 0;
  int check_cnt = 0;
  int pass_cnt  = 0;
  int fail_cnt  = 0;
  bit timed_out = 0;

  // expected dout values and the edge after which each is valid
  rf_data_t exp_q [$];
  int       due_q [$];

  `include "rf_tb_ref.svh"

  rf16x160_top rf16x160_top_i
  (
    .rd_clk   (rd_clk),
    .reset_l  (reset_l),
    .wr_en    (wr_en),
    .wr_adr   (wr_adr),
    .din      (din),
    .word_wen (word_wen),
    .byte_wen (byte_wen),
    .read_en  (read_en),
    .rd_adr   (rd_adr),
    .dout     (dout)
  );

  initial rd_clk = 1'b0;
  always #10 rd_clk = ~rd_clk;

  always @(posedge rd_clk)
  begin
    edge_cnt <= edge_cnt + 1;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check_data(input rf_data_t got, input rf_data_t exp, input string what);
    check_cnt++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  function automatic rf_data_t rand_data();
    rf_data_t d;
    for (int k = 0; k < RF_DATA_W / 32; k++)
    begin
      d[32*k +: 32] = next_rand();
    end
    return d;
  endfunction

  // one cycle of inputs, applied on the falling edge
  task automatic drive_cycle(input logic rd, input rf_addr_t ra, input logic wr,
                             input rf_addr_t wa, input rf_data_t d,
                             input rf_word_wen_t ww, input rf_byte_wen_t bw);
    @(negedge rd_clk);
    read_en  = rd;
    rd_adr   = ra;
    wr_en    = wr;
    wr_adr   = wa;
    din      = d;
    word_wen = ww;
    byte_wen = bw;
    exp_q.push_back(predict_dout(rd, ra, wr, wa, d, ww, bw));
    // sampled at the next edge, dout loads one edge later
    due_q.push_back(edge_cnt + 2);
  endtask

  // park the inputs and let every pending read come out
  task automatic wait_drain();
    int n;
    n = 0;
    drive_cycle(1'b0, '0, 1'b0, '0, '0, '0, '0);
    while (exp_q.size() != 0 && n < DRAIN_LIMIT)
    begin
      @(posedge rd_clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      timed_out = 1'b1;
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < RF_ENTRIES; i++)
    begin
      drive_cycle(1'b1, rf_addr_t'(i), 1'b0, '0, '0, '0, '0);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic write_all_full();
    for (int i = 0; i < RF_ENTRIES; i++)
    begin
      drive_cycle(1'b0, '0, 1'b1, rf_addr_t'(i), rand_data(), '1, '1);
    end
    read_all();
  endtask

  task automatic partial_writes();
    logic [31:0] r;
    for (int i = 0; i < RF_ENTRIES; i++)
    begin
      r = next_rand();
      drive_cycle(1'b0, '0, 1'b1, rf_addr_t'(i), rand_data(), r[3:0], r[23:4]);
    end
    read_all();
  endtask

  // read and write at the same edge, then read the entry right after
  task automatic collide_reads();
    logic [31:0] r;
    for (int i = 0; i < RF_ENTRIES; i++)
    begin
      r = next_rand();
      if (i == 0)
      begin
        r = '1;
      end
      drive_cycle(1'b1, rf_addr_t'(i), 1'b1, rf_addr_t'(i), rand_data(), r[3:0], r[23:4]);
      drive_cycle(1'b1, rf_addr_t'(i), 1'b0, '0, '0, '0, '0);
    end
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    logic [31:0] e;
    for (int n = 0; n < 300; n++)
    begin
      r = next_rand();
      e = next_rand();
      drive_cycle(1'b1, r[11:8], r[0], r[7:4], rand_data(), r[15:12], e[19:0]);
    end
  endtask

  // writes and idle read addresses while read_en stays low
  task automatic hold_when_idle();
    logic [31:0] r;
    drive_cycle(1'b1, 4'd5, 1'b0, '0, '0, '0, '0);
    for (int n = 0; n < 20; n++)
    begin
      r = next_rand();
      drive_cycle(1'b0, r[11:8], r[0], (r[1] ? 4'd5 : r[7:4]), rand_data(), '1, '1);
    end
    drive_cycle(1'b1, 4'd5, 1'b0, '0, '0, '0, '0);
  endtask

  function automatic string test_title(int t);
    case (t)
      1: return "dout after reset";
      2: return "full writes then reads";
      3: return "partial writes by enables";
      4: return "same-edge read and write";
      5: return "random back-to-back traffic";
      default: return "dout holds with read_en low";
    endcase
  endfunction

  task automatic run_test(int t);
    int start_err;
    start_err = err_cnt;
    case (t)
      1: check_data(dout, '0, "dout after reset");
      2: write_all_full();
      3: partial_writes();
      4: collide_reads();
      5: random_traffic();
      default: hold_when_idle();
    endcase
    wait_drain();
    if (timed_out)
    begin
      $display("test %0d %s: read data still pending after %0d cycles", t, test_title(t),
               DRAIN_LIMIT);
      fail_cnt++;
    end
    else if (err_cnt == start_err)
    begin
      $display("test %0d %s: ok", t, test_title(t));
      pass_cnt++;
    end
    else
    begin
      $display("test %0d %s: %0d errors", t, test_title(t), err_cnt - start_err);
      fail_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////

  initial
  begin
    forever
    begin
      @(negedge rd_clk);
      if (due_q.size() > 0 && due_q[0] <= edge_cnt)
      begin
        if (due_q[0] < edge_cnt)
        begin
          $display("read data due after edge %0d was not checked in time", due_q[0]);
          err_cnt++;
        end
        else
        begin
          check_data(dout, exp_q[0], "dout");
        end
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    rng_state  = 32'd57;
    model_dout = '0;
    reset_l    = 1'b1;
    wr_en      = 1'b0;
    wr_adr     = '0;
    din        = '0;
    word_wen   = '0;
    byte_wen   = '0;
    read_en    = 1'b0;
    rd_adr     = '0;
    repeat (2) @(posedge rd_clk);
    @(negedge rd_clk);
    reset_l = 1'b0;
    for (int t = 1; t <= NUM_TESTS && !timed_out; t++)
    begin
      run_test(t);
    end
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (!timed_out && err_cnt == 0 && fail_cnt == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+tb
rtl/rf_pkg.sv
rtl/rf_write_port.sv
rtl/rf_byte_lane.sv
rtl/rf_array.sv
rtl/rf_read_port.sv
rtl/rf16x160_top.sv
tb/rf_tb.sv
